// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    ////////////////////
    // RISC-V load/store width codes.
    localparam logic [2:0] f3_byte   = 3'd0;
    localparam logic [2:0] f3_half   = 3'd1;
    localparam logic [2:0] f3_word   = 3'd2;
    localparam logic [2:0] f3_byte_u = 3'd4;
    localparam logic [2:0] f3_half_u = 3'd5;

    ////////////////////
    // AXI4 encodings.
    localparam logic [2:0] axi_size_byte = 3'd0;
    localparam logic [2:0] axi_size_half = 3'd1;
    localparam logic [2:0] axi_size_word = 3'd2;

    localparam logic [1:0] axi_burst_fixed = 2'b00;
    localparam logic [1:0] axi_burst_incr  = 2'b01;

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // Single beat, fixed ID.
    localparam logic [7:0] axi_len_single = 8'd0;
    localparam logic [3:0] axi_id_lsu     = 4'd0;

endpackage

// ==== src/mem_op_decode.sv ====
`timescale 1ns/1ns

module mem_op_decode import lsu_pkg::*; (
    input  logic [2:0]  funct3,
    input  logic [1:0]  addr_off,
    input  logic [31:0] store_data,
    output logic [2:0]  axi_size,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic        load_signed
);

    logic [3:0] base_mask;

    always_comb begin
        case (funct3)
            f3_byte, f3_byte_u: begin
                axi_size  = axi_size_byte;
                base_mask = 4'b0001;
            end
            f3_half, f3_half_u: begin
                axi_size  = axi_size_half;
                base_mask = 4'b0011;
            end
            f3_word: begin
                axi_size  = axi_size_word;
                base_mask = 4'b1111;
            end
            default: begin
                axi_size  = axi_size_word;
                base_mask = 4'b1111;
            end
        endcase
    end

    // Lane placement follows the low address bits.
    assign wstrb = base_mask << addr_off;
    assign wdata = store_data << {addr_off, 3'b000};

    assign load_signed = !((funct3 == f3_byte_u) || (funct3 == f3_half_u));

endmodule

// ==== src/lsu_axi_master.sv ====
`timescale 1ns/1ns

module lsu_axi_master import lsu_pkg::*; #(
    parameter logic [31:0] sram_base  = 32'hA000_0000,
    parameter int          sram_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        is_load,
    input  logic        is_store,
    input  logic [31:0] addr,
    input  logic [2:0]  axi_size,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    input  logic        load_signed,
    input  logic [2:0]  funct3,
    input  logic        result_busy,

    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] awaddr,
    output logic [3:0]  awid,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic        wvalid,
    input  logic        wready,
    output logic [31:0] wdata_o,
    output logic [3:0]  wstrb_o,
    output logic        wlast,
    input  logic        bvalid,
    output logic        bready,
    input  logic [1:0]  bresp,
    input  logic [3:0]  bid,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  logic [1:0]  rresp,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic [3:0]  rid,

    output logic        rsp_done,
    output logic [31:0] rsp_data,
    output logic        rsp_fault,
    output logic        rsp_passthru,
    output logic [1:0]  rsp_off,
    output logic [2:0]  rsp_funct3,
    output logic        rsp_signed
);

    localparam logic [31:0] sram_bytes = 32'(sram_words) << 2;

    typedef enum logic {st_idle, st_busy} state_t;

    state_t      state;
    logic        accept;
    logic [31:0] win_off;
    logic [1:0]  burst;

    assign in_ready = (state == st_idle) && !result_busy;
    assign accept   = in_valid && in_ready;

    // INCR inside the SRAM window, FIXED for device space.
    assign win_off = addr - sram_base;
    assign burst   = (win_off < sram_bytes) ? axi_burst_incr : axi_burst_fixed;

    assign awid  = axi_id_lsu;
    assign awlen = axi_len_single;
    assign wlast = 1'b1;
    assign arid  = axi_id_lsu;
    assign arlen = axi_len_single;

    ////////////////////
    // Transaction FSM.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            rsp_done <= 1'b0;
        end else begin
            rsp_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept && is_load) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= st_busy;
                    end else if (accept && is_store) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        bready  <= 1'b1;
                        state   <= st_busy;
                    end else if (accept) begin
                        rsp_done <= 1'b1;
                    end
                end
                st_busy: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        rready   <= 1'b0;
                        bready   <= 1'b0;
                        rsp_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////
    // Request and response payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            araddr       <= addr;
            arsize       <= axi_size;
            arburst      <= burst;
            awaddr       <= addr;
            awsize       <= axi_size;
            awburst      <= burst;
            wdata_o      <= wdata;
            wstrb_o      <= wstrb;
            rsp_off      <= addr[1:0];
            rsp_funct3   <= funct3;
            rsp_signed   <= load_signed;
            rsp_passthru <= !(is_load || is_store);
            rsp_data     <= addr;
            rsp_fault    <= 1'b0;
        end
        // A wrong ID or a missing last beat counts as a bus error too.
        if (rvalid && rready) begin
            rsp_data  <= rdata;
            rsp_fault <= (rresp != axi_resp_okay) || (rid != axi_id_lsu) || !rlast;
        end
        if (bvalid && bready) begin
            rsp_data  <= '0;
            rsp_fault <= (bresp != axi_resp_okay) || (bid != axi_id_lsu);
        end
    end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/1ns

module load_align import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rsp_done,
    input  logic [31:0] rsp_data,
    input  logic        rsp_fault,
    input  logic        rsp_passthru,
    input  logic [1:0]  rsp_off,
    input  logic [2:0]  rsp_funct3,
    input  logic        rsp_signed,
    input  logic        out_ready,
    output logic        out_valid,
    output logic [31:0] load_data,
    output logic        access_fault,
    output logic        result_busy
);

    logic [31:0] shifted;
    logic [31:0] result;

    assign shifted = rsp_data >> {rsp_off, 3'b000};

    always_comb begin
        case (rsp_funct3)
            f3_byte, f3_byte_u: result = {{24{rsp_signed & shifted[7]}}, shifted[7:0]};
            f3_half, f3_half_u: result = {{16{rsp_signed & shifted[15]}}, shifted[15:0]};
            default:            result = shifted;
        endcase
        if (rsp_passthru) begin
            result = rsp_data;
        end else if (rsp_fault) begin
            result = '0;
        end
    end

    // Busy from the done pulse until writeback takes the result.
    assign result_busy = rsp_done || (out_valid && !out_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid    <= 1'b0;
            access_fault <= 1'b0;
        end else if (rsp_done) begin
            out_valid    <= 1'b1;
            access_fault <= rsp_fault;
        end else if (out_valid && out_ready) begin
            out_valid    <= 1'b0;
            access_fault <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_done) begin
            load_data <= result;
        end
    end

endmodule

// ==== src/axi_sram.sv ====
`timescale 1ns/1ns

module axi_sram import lsu_pkg::*; #(
    parameter logic [31:0] sram_base  = 32'hA000_0000,
    parameter int          sram_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic [3:0]  awid,
    input  logic [7:0]  awlen,
    input  logic [2:0]  awsize,
    input  logic [1:0]  awburst,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    output logic [3:0]  bid,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    output logic        rvalid,
    input  logic        rready,
    output logic [1:0]  rresp,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic [3:0]  rid
);

    localparam int          idx_w      = $clog2(sram_words);
    localparam logic [31:0] sram_bytes = 32'(sram_words) << 2;

    typedef enum logic [1:0] {st_idle, st_read, st_write} state_t;

    state_t      state;
    logic [31:0] mem [sram_words];
    logic        aw_got;
    logic        w_got;
    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        wr_fire;
    logic        aw_ok;
    logic        ar_ok;
    logic        wr_ok;
    logic        aw_ok_q;
    logic        w_ok_q;
    logic [31:0] aw_addr_q;
    logic [3:0]  aw_id_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;

    // Single beat, supported size and burst, inside the window.
    function automatic logic req_ok(input logic [31:0] a, input logic [7:0] len,
                                    input logic [2:0] size, input logic [1:0] burst);
        logic [31:0] off;
        off = a - sram_base;
        return (off < sram_bytes) && (len == axi_len_single) && (size <= axi_size_word) &&
               ((burst == axi_burst_fixed) || (burst == axi_burst_incr));
    endfunction

    function automatic logic [idx_w-1:0] word_idx(input logic [31:0] a);
        logic [31:0] off;
        off = a - sram_base;
        return off[idx_w+1:2];
    endfunction

    // Reads only start with no write half accepted.
    assign arready = (state == st_idle) && !aw_got && !w_got;
    assign awready = (state == st_idle) && !aw_got && !arvalid;
    assign wready  = (state == st_idle) && !w_got && !arvalid;
    assign rlast   = 1'b1;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    assign aw_ok   = req_ok(awaddr, awlen, awsize, awburst);
    assign ar_ok   = req_ok(araddr, arlen, arsize, arburst);
    assign wr_addr = aw_got ? aw_addr_q : awaddr;
    assign wr_data = w_got ? w_data_q : wdata;
    assign wr_strb = w_got ? w_strb_q : wstrb;
    assign wr_ok   = (aw_got ? aw_ok_q : aw_ok) && (w_got ? w_ok_q : wlast);
    assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            for (int i = 0; i < sram_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (ar_hs) begin
                        rvalid <= 1'b1;
                        state  <= st_read;
                    end else if (wr_fire) begin
                        bvalid <= 1'b1;
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                        state  <= st_write;
                        for (int b = 0; b < 4; b++) begin
                            if (wr_ok && wr_strb[b]) begin
                                mem[word_idx(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
                            end
                        end
                    end else begin
                        aw_got <= aw_got || aw_hs;
                        w_got  <= w_got || w_hs;
                    end
                end
                st_read: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                st_write: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
            aw_id_q   <= awid;
            aw_ok_q   <= aw_ok;
        end
        if (w_hs) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
            w_ok_q   <= wlast;
        end
        if (ar_hs) begin
            rdata <= ar_ok ? mem[word_idx(araddr)] : '0;
            rresp <= ar_ok ? axi_resp_okay : axi_resp_slverr;
            rid   <= arid;
        end
        if (wr_fire) begin
            bresp <= wr_ok ? axi_resp_okay : axi_resp_slverr;
            bid   <= aw_got ? aw_id_q : awid;
        end
    end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
    parameter logic [31:0] sram_base  = 32'hA000_0000,
    parameter int          sram_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        is_load,
    input  logic        is_store,
    input  logic [2:0]  funct3,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] load_data,
    output logic        access_fault
);

    // Decoded operation fields.
    logic [2:0]  axi_size;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        load_signed;
    logic        result_busy;

    // AXI4 bus between master and SRAM.
    logic        awvalid, awready;
    logic [31:0] awaddr;
    logic [3:0]  awid;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic        wvalid, wready, wlast;
    logic [31:0] wdata_o;
    logic [3:0]  wstrb_o;
    logic        bvalid, bready;
    logic [1:0]  bresp;
    logic [3:0]  bid;
    logic        arvalid, arready;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid, rready, rlast;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    logic [3:0]  rid;

    // Response to the result stage.
    logic        rsp_done, rsp_fault, rsp_passthru, rsp_signed;
    logic [31:0] rsp_data;
    logic [1:0]  rsp_off;
    logic [2:0]  rsp_funct3;

    mem_op_decode decode_i (.*, .addr_off(addr[1:0]));

    lsu_axi_master #(.sram_base(sram_base), .sram_words(sram_words)) master_i (.*);

    load_align align_i (.*);

    axi_sram #(.sram_base(sram_base), .sram_words(sram_words)) sram_i (
        .*,
        .wdata(wdata_o),
        .wstrb(wstrb_o)
    );

endmodule

// ==== sim/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker (
    input logic        clk,
    input logic        rst,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        bvalid,
    input logic        bready,
    input logic        arvalid,
    input logic        arready,
    input logic        rvalid,
    input logic        rready,
    input logic        in_valid,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] load_data,
    input logic        access_fault
);

    int   fail_count = 0;
    logic pending;

    // An accepted operation stays pending until writeback takes its result.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (in_valid && in_ready) begin
            pending <= 1'b1;
        end else if (out_valid && out_ready) begin
            pending <= 1'b0;
        end
    end

    ////////////////////
    // AXI valids hold until their handshake.
    aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    ////////////////////
    // Writeback side.
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(load_data) && $stable(access_fault))
        else begin
            $error("result changed or dropped before out_ready");
            fail_count++;
        end

    // No new operation from acceptance until the result is taken.
    busy_hold: assert property (@(posedge clk) disable iff (rst)
        pending && !(out_valid && out_ready) |-> !in_ready)
        else begin
            $error("in_ready high while an operation is pending");
            fail_count++;
        end

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

    localparam logic [31:0] sram_base    = 32'hA000_0000;
    localparam int          sram_words   = 256;
    localparam logic [31:0] window_bytes = 32'(sram_words * 4);
    localparam int          max_ops      = 400;
    localparam int          op_cycles    = 40;
    localparam int          max_cycles   = max_ops * op_cycles;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic        is_load;
    logic        is_store;
    logic [2:0]  funct3;
    logic [31:0] addr;
    logic [31:0] store_data;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] load_data;
    logic        access_fault;

    logic [15:0] lfsr;
    logic [31:0] ref_mem [sram_words];
    int          checks;
    int          errors;
    int          ops;
    int          phase_ops;
    int          phase_errors;

    lsu_top #(.sram_base(sram_base), .sram_words(sram_words)) lsu_top_i (.*);

    bind lsu_top lsu_checker checker_i (
        .clk(clk),
        .rst(rst),
        .awvalid(awvalid),
        .awready(awready),
        .wvalid(wvalid),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready),
        .arvalid(arvalid),
        .arready(arready),
        .rvalid(rvalid),
        .rready(rready),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .load_data(load_data),
        .access_fault(access_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Random source with taps x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [2:0] pick_load_f3();
        logic [31:0] r;
        r = rand_bits(3);
        case (r)
            32'd0:   return f3_byte;
            32'd1:   return f3_half;
            32'd2:   return f3_byte_u;
            32'd3:   return f3_half_u;
            default: return f3_word;
        endcase
    endfunction

    function automatic logic [2:0] pick_store_f3();
        logic [31:0] r;
        r = rand_bits(2);
        case (r)
            32'd0:   return f3_byte;
            32'd1:   return f3_half;
            default: return f3_word;
        endcase
    endfunction

    // Aligned byte offset for the access width.
    function automatic logic [31:0] rand_off(input logic [2:0] f3);
        case (f3)
            f3_byte, f3_byte_u: return rand_bits(2);
            f3_half, f3_half_u: return rand_bits(1) << 1;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] word_addr();
        return sram_base + (rand_bits(8) << 2);
    endfunction

    function automatic logic [31:0] fault_addr(input logic [2:0] f3);
        logic [31:0] off;
        logic [31:0] word;
        off = rand_off(f3);
        if (rand_bits(1) != 32'd0) begin
            word = sram_base + window_bytes + (rand_bits(8) << 2);
        end else begin
            word = 32'h4000_0000 + (rand_bits(26) << 2);
        end
        return word + off;
    endfunction

    ////////////////////
    // Reference memory model.
    function automatic logic in_window(input logic [31:0] a);
        return (a >= sram_base) && (a < sram_base + window_bytes);
    endfunction

    function automatic logic [7:0] word_index(input logic [31:0] a);
        logic [31:0] off;
        off = a - sram_base;
        return off[9:2];
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[word_index(a)];
        b = w[{a[1:0], 3'b000} +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (f3)
            f3_byte:   return {{24{b[7]}}, b};
            f3_byte_u: return {24'h0, b};
            f3_half:   return {{16{h[15]}}, h};
            f3_half_u: return {16'h0, h};
            default:   return w;
        endcase
    endfunction

    function automatic void model_store(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] sd);
        logic [7:0] idx;
        idx = word_index(a);
        case (f3)
            f3_byte: ref_mem[idx][{a[1:0], 3'b000} +: 8] = sd[7:0];
            f3_half: begin
                if (a[1]) begin
                    ref_mem[idx][31:16] = sd[15:0];
                end else begin
                    ref_mem[idx][15:0] = sd[15:0];
                end
            end
            default: ref_mem[idx] = sd;
        endcase
    endfunction

    ////////////////////
    // Checks and reporting.
    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic finish_phase(input string name);
        $display("%s: %0d operations, %0d errors", name, ops - phase_ops, errors - phase_errors);
        phase_ops    = ops;
        phase_errors = errors;
    endtask

    // One operation from hand-over to writeback; called just after a rising edge.
    task automatic do_op(input logic ld, input logic st, input logic [2:0] f3,
                         input logic [31:0] a, input logic [31:0] sd, input logic bp);
        logic [31:0] exp_data;
        logic        exp_fault;
        logic [31:0] held_data;
        logic        held_fault;
        logic        seen;
        logic        taken;
        int          n;
        int          lat;
        if (!ld && !st) begin
            exp_data  = a;
            exp_fault = 1'b0;
        end else if (!in_window(a)) begin
            exp_data  = '0;
            exp_fault = 1'b1;
        end else if (ld) begin
            exp_data  = model_load(f3, a);
            exp_fault = 1'b0;
        end else begin
            exp_data  = '0;
            exp_fault = 1'b0;
            model_store(f3, a, sd);
        end
        in_valid   <= 1'b1;
        is_load    <= ld;
        is_store   <= st;
        funct3     <= f3;
        addr       <= a;
        store_data <= sd;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        is_load  <= 1'b0;
        is_store <= 1'b0;
        seen       = 1'b0;
        taken      = 1'b0;
        held_data  = '0;
        held_fault = 1'b0;
        n          = 0;
        lat        = 0;
        while (!taken) begin
            if (bp) begin
                out_ready <= (rand_bits(1) != 32'd0);
            end
            @(negedge clk);
            n++;
            if (out_valid && !seen) begin
                seen       = 1'b1;
                lat        = n - 1;
                held_data  = load_data;
                held_fault = access_fault;
            end else if (out_valid) begin
                check_val("held load_data", held_data, load_data);
                check_val("held access_fault", 32'(held_fault), 32'(access_fault));
            end
            if (out_valid && !out_ready) begin
                check_true(!in_ready, "in_ready went high while a result was held");
            end
            taken = out_valid && out_ready;
            @(posedge clk);
        end
        ops++;
        check_val("load_data", exp_data, held_data);
        check_val("access_fault", 32'(exp_fault), 32'(held_fault));
        if (!ld && !st) begin
            check_val("passthrough latency", 32'd1, 32'(lat));
        end else begin
            check_true(lat >= 3, "memory access finished in under 3 cycles");
        end
    endtask

    ////////////////////
    // Test sequence.
    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [2:0]  f3;
        logic [31:0] word_addrs [$];
        int          kind;
        logic        fault_ld;
        lfsr         = 16'd59;
        ref_mem      = '{default: '0};
        checks       = 0;
        errors       = 0;
        ops          = 0;
        phase_ops    = 0;
        phase_errors = 0;
        rst        <= 1'b1;
        in_valid   <= 1'b0;
        is_load    <= 1'b0;
        is_store   <= 1'b0;
        funct3     <= 3'd0;
        addr       <= '0;
        store_data <= '0;
        out_ready  <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("in_ready", 32'd1, 32'(in_ready));
        check_val("out_valid", 32'd0, 32'(out_valid));
        check_val("access_fault", 32'd0, 32'(access_fault));
        finish_phase("reset state");
        @(posedge clk);

        for (int i = 0; i < 32; i++) begin
            a = word_addr();
            d = rand_bits(32);
            do_op(1'b0, 1'b1, f3_word, a, d, 1'b0);
            word_addrs.push_back(a);
        end
        while (word_addrs.size() > 0) begin
            a = word_addrs.pop_front();
            do_op(1'b1, 1'b0, f3_word, a, '0, 1'b0);
        end
        finish_phase("word round trip");

        // Every byte offset, then both half offsets.
        // The word is filled first so a stray lane shows in the merge.
        for (int rep = 0; rep < 5; rep++) begin
            for (int c = 0; c < 6; c++) begin
                a  = word_addr();
                f3 = (c < 4) ? f3_byte : f3_half;
                d  = (c < 4) ? 32'(c) : 32'((c - 4) * 2);
                do_op(1'b0, 1'b1, f3_word, a, rand_bits(32), 1'b0);
                do_op(1'b0, 1'b1, f3, a + d, rand_bits(32), 1'b0);
                do_op(1'b1, 1'b0, f3_word, a, '0, 1'b0);
            end
        end
        finish_phase("partial stores");

        for (int rep = 0; rep < 4; rep++) begin
            a = word_addr();
            do_op(1'b0, 1'b1, f3_word, a, rand_bits(32), 1'b0);
            for (int c = 0; c < 12; c++) begin
                if (c < 4) begin
                    f3 = f3_byte;
                    d  = 32'(c);
                end else if (c < 8) begin
                    f3 = f3_byte_u;
                    d  = 32'(c - 4);
                end else if (c < 10) begin
                    f3 = f3_half;
                    d  = 32'((c - 8) * 2);
                end else begin
                    f3 = f3_half_u;
                    d  = 32'((c - 10) * 2);
                end
                do_op(1'b1, 1'b0, f3, a + d, '0, 1'b0);
            end
        end
        finish_phase("load extension");

        // The word load after a faulting store catches any aliased write.
        for (int i = 0; i < 8; i++) begin
            f3 = pick_store_f3();
            a  = fault_addr(f3);
            do_op(1'b0, 1'b1, f3, a, rand_bits(32), 1'b0);
            do_op(1'b1, 1'b0, f3_word, sram_base + (a & 32'h3FC), '0, 1'b0);
            f3 = pick_load_f3();
            a  = fault_addr(f3);
            do_op(1'b1, 1'b0, f3, a, '0, 1'b0);
        end
        finish_phase("faults");

        for (int i = 0; i < 16; i++) begin
            f3 = 3'(rand_bits(3));
            a  = rand_bits(32);
            do_op(1'b0, 1'b0, f3, a, rand_bits(32), 1'b0);
        end
        finish_phase("passthrough");

        for (int i = 0; i < 150; i++) begin
            kind = rand_bits(3);
            if (kind < 3) begin
                f3 = pick_load_f3();
                a  = word_addr() + rand_off(f3);
                do_op(1'b1, 1'b0, f3, a, '0, 1'b1);
            end else if (kind < 6) begin
                f3 = pick_store_f3();
                a  = word_addr() + rand_off(f3);
                do_op(1'b0, 1'b1, f3, a, rand_bits(32), 1'b1);
            end else if (kind == 6) begin
                a = rand_bits(32);
                do_op(1'b0, 1'b0, f3_word, a, '0, 1'b1);
            end else begin
                fault_ld = (rand_bits(1) != 32'd0);
                f3       = fault_ld ? pick_load_f3() : pick_store_f3();
                a        = fault_addr(f3);
                do_op(fault_ld, !fault_ld, f3, a, rand_bits(32), 1'b1);
            end
        end
        out_ready <= 1'b1;
        finish_phase("back-pressure mix");

        errors += lsu_top_i.checker_i.fail_count;
        $display("summary: %0d operations, %0d checks, %0d errors, %0d assertion failures",
                 ops, checks, errors, lsu_top_i.checker_i.fail_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/lsu_pkg.sv
src/mem_op_decode.sv
src/lsu_axi_master.sv
src/load_align.sv
src/axi_sram.sv
src/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f src/*.sv sim/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
